/* crc32_gen.sv */
module crc32_gen (
	input  logic        fifo_clk,
	input  logic        sys_rst,
	input  logic        init,
	input  logic        en,
	input  logic [7:0]  data,
	output logic [31:0] crc
);

	// IEEE 802.3 polynomial in reflected form
	localparam logic [31:0] crc_poly = 32'hedb88320;

	logic [31:0] crc_reg;

	// One byte through the shift register, LSB first as on the wire
	function automatic logic [31:0] crc_byte(input logic [31:0] c, input logic [7:0] d);
		logic [31:0] r;
		r = c;
		for (int i = 0; i < 8; i++) begin
			if (r[0] ^ d[i]) begin
				r = (r >> 1) ^ crc_poly;
			end else begin
				r = r >> 1;
			end
		end
		return r;
	endfunction

	always_ff @(posedge fifo_clk) begin
		if (sys_rst) begin
			crc_reg <= 32'hffff_ffff;
		end else if (init) begin
			crc_reg <= 32'hffff_ffff;
		end else if (en) begin
			crc_reg <= crc_byte(crc_reg, data);
		end
	end

	// ----------------------------------------------------------
	// Transmit order
	// ----------------------------------------------------------
	// Low register byte goes out first, so it lands in the top byte
	assign crc = ~{crc_reg[7:0], crc_reg[15:8], crc_reg[23:16], crc_reg[31:24]};

endmodule

/* frame_sequencer.sv */
module frame_sequencer
	import gmii_pkg::*;
#(
	parameter logic [47:0] SRC_MAC = 48'h00_23_45_67_89_01,
	parameter logic [47:0] DST_MAC = 48'h00_23_45_67_89_02,
	parameter logic [31:0] SRC_IP = {8'd192, 8'd168, 8'd0, 8'd1},
	parameter logic [31:0] DST_IP = {8'd192, 8'd168, 8'd0, 8'd2}
) (
	input  logic        fifo_clk,
	input  logic        sys_rst,
	input  logic        node_id,
	input  logic        line_commit,
	input  video_word_u fifo_word,
	input  logic [15:0] ip_csum,
	input  logic [31:0] crc,
	output logic        fifo_rd,
	output logic        sum_start,
	output logic [7:0]  pair_count,
	output logic        crc_init,
	output logic        crc_en,
	output logic [7:0]  crc_data,
	output gmii_tx_t    gmii_out
);

	typedef enum logic [2:0] {
		st_idle,
		st_preamble,
		st_sfd,
		st_header,
		st_coord,
		st_pixel,
		st_fcs,
		st_gap
	} seq_state_t;

	seq_state_t       state;
	logic [5:0]       byte_cnt;
	logic [7:0]       word_cnt;
	logic [3:0]       pending;
	logic             frame_go;
	logic             last_word;
	logic [0:41][7:0] hdr_bytes;
	logic [7:0]       tx_byte;
	logic             tx_valid;

	assign frame_go = (state == st_idle) && (pending != 4'd0);
	assign last_word = (word_cnt == pair_count - 8'd1);

	// ----------------------------------------------------------
	// Ethernet, IPv4 and UDP headers as one byte table
	// ----------------------------------------------------------
	assign hdr_bytes = {
		DST_MAC[47:8], node_sub(DST_MAC[7:0], node_id),
		SRC_MAC[47:8], node_add(SRC_MAC[7:0], node_id),
		eth_type_ipv4,
		ip_ver_tos, ip_total_length(pair_count), ip_ident, ip_flags, ip_ttl_proto,
		ip_csum,
		SRC_IP[31:8], node_add(SRC_IP[7:0], node_id),
		DST_IP[31:8], node_sub(DST_IP[7:0], node_id),
		udp_src_port, udp_dst_port, udp_length(pair_count), 16'h0000
	};

	// Byte chosen this cycle, seen on gmii_out one cycle later
	always_comb begin
		tx_valid = 1'b1;
		tx_byte = 8'h00;
		case (state)
			st_preamble: tx_byte = 8'h55;
			st_sfd: tx_byte = 8'hd5;
			st_header: tx_byte = hdr_bytes[byte_cnt];
			st_coord: begin
				case (byte_cnt[2:0])
					3'd0: tx_byte = pkt_type_video;
					3'd1: tx_byte = {4'h0, fifo_word.coord.line_y[11:8]};
					3'd2: tx_byte = fifo_word.coord.line_y[7:0];
					3'd3: tx_byte = {4'h0, fifo_word.coord.col_x[11:8]};
					default: tx_byte = fifo_word.coord.col_x[7:0];
				endcase
			end
			st_pixel: begin
				case (byte_cnt[1:0])
					2'd0: tx_byte = fifo_word.pixel.y0;
					2'd1: tx_byte = fifo_word.pixel.cb;
					2'd2: tx_byte = fifo_word.pixel.y1;
					default: tx_byte = fifo_word.pixel.cr;
				endcase
			end
			st_fcs: begin
				case (byte_cnt[1:0])
					2'd0: tx_byte = crc[31:24];
					2'd1: tx_byte = crc[23:16];
					2'd2: tx_byte = crc[15:8];
					default: tx_byte = crc[7:0];
				endcase
			end
			default: tx_valid = 1'b0;
		endcase
	end

	// ----------------------------------------------------------
	// FIFO reads, checksum start and CRC control
	// ----------------------------------------------------------
	// Coordinate word at frame start, then each pixel word is fetched
	// on the last byte of the word before it
	assign fifo_rd = frame_go
		|| (state == st_coord && byte_cnt == 6'd4)
		|| (state == st_pixel && byte_cnt[1:0] == 2'd3 && !last_word);

	// pair_count is latched on the first preamble byte
	assign sum_start = (state == st_preamble) && (byte_cnt == 6'd1);

	assign crc_init = (state == st_sfd);
	assign crc_en = (state == st_header) || (state == st_coord) || (state == st_pixel);
	assign crc_data = tx_byte;

	always_ff @(posedge fifo_clk) begin
		if (sys_rst) begin
			state <= st_idle;
			byte_cnt <= '0;
			word_cnt <= '0;
			pending <= '0;
			pair_count <= '0;
			gmii_out <= '0;
		end else begin
			gmii_out.en <= tx_valid;
			gmii_out.data <= tx_byte;

			// Committed lines waiting for a frame
			if (line_commit && !frame_go) begin
				pending <= pending + 4'd1;
			end else if (frame_go && !line_commit) begin
				pending <= pending - 4'd1;
			end

			byte_cnt <= byte_cnt + 6'd1;
			case (state)
				st_idle: begin
					byte_cnt <= '0;
					if (frame_go) begin
						state <= st_preamble;
					end
				end
				st_preamble: begin
					if (byte_cnt == 6'd0) begin
						pair_count <= fifo_word.coord.pair_count;
					end
					if (byte_cnt == 6'(preamble_len - 1)) begin
						state <= st_sfd;
					end
				end
				st_sfd: begin
					byte_cnt <= '0;
					state <= st_header;
				end
				st_header: begin
					if (byte_cnt == 6'd41) begin
						byte_cnt <= '0;
						state <= st_coord;
					end
				end
				st_coord: begin
					if (byte_cnt == 6'd4) begin
						byte_cnt <= '0;
						word_cnt <= '0;
						state <= st_pixel;
					end
				end
				st_pixel: begin
					if (byte_cnt[1:0] == 2'd3) begin
						word_cnt <= word_cnt + 8'd1;
						if (last_word) begin
							byte_cnt <= '0;
							state <= st_fcs;
						end
					end
				end
				st_fcs: begin
					if (byte_cnt == 6'd3) begin
						byte_cnt <= '0;
						state <= st_gap;
					end
				end
				default: begin
					if (byte_cnt == 6'(gap_len - 1)) begin
						state <= st_idle;
					end
				end
			endcase
		end
	end

endmodule

/* gmii_pkg.sv */
package gmii_pkg;

	// ----------------------------------------------------------
	// Video words
	// ----------------------------------------------------------

	// First word of a line
	typedef struct packed {
		logic [11:0] line_y;
		logic [11:0] col_x;
		logic [7:0]  pair_count;
	} coord_word_t;

	// Every later word of a line, two pixels in YUV 4:2:2
	typedef struct packed {
		logic [7:0] y0;
		logic [7:0] cb;
		logic [7:0] y1;
		logic [7:0] cr;
	} pixel_word_t;

	typedef union packed {
		coord_word_t coord;
		pixel_word_t pixel;
	} video_word_u;

	// GMII transmit byte lane
	typedef struct packed {
		logic       en;
		logic [7:0] data;
	} gmii_tx_t;

	// ----------------------------------------------------------
	// Protocol constants
	// ----------------------------------------------------------
	localparam logic [15:0] eth_type_ipv4 = 16'h0800;
	localparam logic [15:0] udp_src_port = 16'h3038;
	localparam logic [15:0] udp_dst_port = 16'h3039;
	localparam logic [15:0] ip_ver_tos = 16'h4500;
	localparam logic [15:0] ip_ident = 16'h0000;
	localparam logic [15:0] ip_flags = 16'h4000;
	localparam logic [15:0] ip_ttl_proto = 16'h4011;
	localparam logic [7:0]  pkt_type_video = 8'h00;
	localparam int preamble_len = 7;
	localparam int gap_len = 12;

	// UDP header 8 + type 1 + coordinates 4
	localparam int fixed_len = 13;
	localparam int ip_hdr_len = 20;

	function automatic logic [15:0] udp_length(input logic [7:0] pairs);
		return 16'(fixed_len) + {6'b0, pairs, 2'b00};
	endfunction

	function automatic logic [15:0] ip_total_length(input logic [7:0] pairs);
		return udp_length(pairs) + 16'(ip_hdr_len);
	endfunction

	// Node id moves the low address byte up on the source side
	function automatic logic [7:0] node_add(input logic [7:0] base, input logic node_id);
		return base + {7'b0, node_id};
	endfunction

	function automatic logic [7:0] node_sub(input logic [7:0] base, input logic node_id);
		return base - {7'b0, node_id};
	endfunction

endpackage

/* gmii_video_tx.sv */
module gmii_video_tx
	import gmii_pkg::*;
#(
	parameter logic [47:0] SRC_MAC = 48'h00_23_45_67_89_01,
	parameter logic [47:0] DST_MAC = 48'h00_23_45_67_89_02,
	parameter logic [31:0] SRC_IP = {8'd192, 8'd168, 8'd0, 8'd1},
	parameter logic [31:0] DST_IP = {8'd192, 8'd168, 8'd0, 8'd2},
	parameter int          FIFO_DEPTH = 64
) (
	input  logic        fifo_clk,
	input  logic        sys_rst,
	input  logic        node_id,
	input  logic        word_wr,
	input  video_word_u word_in,
	input  logic        line_commit,
	output gmii_tx_t    gmii_out,
	output logic        fifo_full
);

	logic        fifo_rd;
	video_word_u fifo_word;
	logic        sum_start;
	logic [7:0]  pair_count;
	logic [15:0] ip_csum;
	logic        crc_init;
	logic        crc_en;
	logic [7:0]  crc_data;
	logic [31:0] crc_value;

	line_fifo #(
		.FIFO_DEPTH(FIFO_DEPTH)
	) u_line_fifo (
		.fifo_clk(fifo_clk),
		.sys_rst(sys_rst),
		.wr(word_wr),
		.wr_word(word_in),
		.rd(fifo_rd),
		.rd_word(fifo_word),
		.full(fifo_full)
	);

	frame_sequencer #(
		.SRC_MAC(SRC_MAC),
		.DST_MAC(DST_MAC),
		.SRC_IP(SRC_IP),
		.DST_IP(DST_IP)
	) u_frame_sequencer (
		.fifo_clk(fifo_clk),
		.sys_rst(sys_rst),
		.node_id(node_id),
		.line_commit(line_commit),
		.fifo_word(fifo_word),
		.ip_csum(ip_csum),
		.crc(crc_value),
		.fifo_rd(fifo_rd),
		.sum_start(sum_start),
		.pair_count(pair_count),
		.crc_init(crc_init),
		.crc_en(crc_en),
		.crc_data(crc_data),
		.gmii_out(gmii_out)
	);

	ip_header_sum #(
		.SRC_IP(SRC_IP),
		.DST_IP(DST_IP)
	) u_ip_header_sum (
		.fifo_clk(fifo_clk),
		.sys_rst(sys_rst),
		.start(sum_start),
		.node_id(node_id),
		.pair_count(pair_count),
		.ip_csum(ip_csum)
	);

	crc32_gen u_crc32_gen (
		.fifo_clk(fifo_clk),
		.sys_rst(sys_rst),
		.init(crc_init),
		.en(crc_en),
		.data(crc_data),
		.crc(crc_value)
	);

endmodule

/* ip_header_sum.sv */
module ip_header_sum
	import gmii_pkg::*;
#(
	parameter logic [31:0] SRC_IP = {8'd192, 8'd168, 8'd0, 8'd1},
	parameter logic [31:0] DST_IP = {8'd192, 8'd168, 8'd0, 8'd2}
) (
	input  logic        fifo_clk,
	input  logic        sys_rst,
	input  logic        start,
	input  logic        node_id,
	input  logic [7:0]  pair_count,
	output logic [15:0] ip_csum
);

	logic [15:0] src_lo;
	logic [15:0] dst_lo;
	logic [19:0] sum_wide;
	logic [16:0] fold_1;
	logic [15:0] fold_2;

	assign src_lo = {SRC_IP[15:8], node_add(SRC_IP[7:0], node_id)};
	assign dst_lo = {DST_IP[15:8], node_sub(DST_IP[7:0], node_id)};

	// ----------------------------------------------------------
	// Ten header words
	// ----------------------------------------------------------
	// Checksum word itself counts as zero and is left out
	assign sum_wide = 20'(ip_ver_tos)
		+ 20'(ip_total_length(pair_count))
		+ 20'(ip_ident)
		+ 20'(ip_flags)
		+ 20'(ip_ttl_proto)
		+ 20'(SRC_IP[31:16])
		+ 20'(src_lo)
		+ 20'(DST_IP[31:16])
		+ 20'(dst_lo);

	// End-around carry
	// second fold can carry at most once more
	assign fold_1 = {1'b0, sum_wide[15:0]} + 17'(sum_wide[19:16]);
	assign fold_2 = fold_1[15:0] + 16'(fold_1[16]);

	always_ff @(posedge fifo_clk) begin
		if (sys_rst) begin
			ip_csum <= '0;
		end else if (start) begin
			ip_csum <= ~fold_2;
		end
	end

endmodule

/* line_fifo.sv */
module line_fifo
	import gmii_pkg::*;
#(
	parameter int FIFO_DEPTH = 64
) (
	input  logic        fifo_clk,
	input  logic        sys_rst,
	input  logic        wr,
	input  video_word_u wr_word,
	input  logic        rd,
	output video_word_u rd_word,
	output logic        full
);

	localparam int PTR_W = $clog2(FIFO_DEPTH);
	localparam int CNT_W = $clog2(FIFO_DEPTH + 1);

	video_word_u      mem [FIFO_DEPTH];
	logic [PTR_W-1:0] wr_ptr;
	logic [PTR_W-1:0] rd_ptr;
	logic [CNT_W-1:0] count;
	logic [CNT_W-1:0] count_next;
	logic             do_wr;
	logic             do_rd;

	// Pointer wrap also covers depths that are not a power of two
	function automatic logic [PTR_W-1:0] ptr_inc(input logic [PTR_W-1:0] p);
		if (p == PTR_W'(FIFO_DEPTH - 1)) begin
			return '0;
		end
		return p + PTR_W'(1);
	endfunction

	// Writes into a full buffer are lost
	assign do_wr = wr && !full;
	assign do_rd = rd && (count != '0);

	always_comb begin
		count_next = count;
		if (do_wr && !do_rd) begin
			count_next = count + CNT_W'(1);
		end else if (do_rd && !do_wr) begin
			count_next = count - CNT_W'(1);
		end
	end

	always_ff @(posedge fifo_clk) begin
		if (sys_rst) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count <= '0;
			full <= 1'b0;
		end else begin
			if (do_wr) begin
				wr_ptr <= ptr_inc(wr_ptr);
			end
			if (do_rd) begin
				rd_ptr <= ptr_inc(rd_ptr);
			end
			count <= count_next;
			full <= (count_next == CNT_W'(FIFO_DEPTH));
		end
	end

	// Storage and registered read port
	always_ff @(posedge fifo_clk) begin
		if (do_wr) begin
			mem[wr_ptr] <= wr_word;
		end
		if (do_rd) begin
			rd_word <= mem[rd_ptr];
		end
	end

endmodule

/* list.f */
gmii_pkg.sv
crc32_gen.sv
ip_header_sum.sv
line_fifo.sv
frame_sequencer.sv
gmii_video_tx.sv
tb_gmii_video_tx.sv

/* tb_gmii_video_tx.sv */
module tb_gmii_video_tx
	import gmii_pkg::*;
();

	timeunit 1ns;
	timeprecision 1ps;

	localparam logic [47:0] tb_src_mac = 48'h02_11_22_33_44_10;
	localparam logic [47:0] tb_dst_mac = 48'h02_55_66_77_88_20;
	localparam logic [31:0] tb_src_ip = 32'h0a00_0307;
	localparam logic [31:0] tb_dst_ip = 32'h0a00_0309;
	localparam int ifg_cycles = 12;
	localparam int start_limit = 100;
	localparam int clk_period = 10;

	typedef logic [7:0] byte_q_t[$];
	typedef video_word_u word_q_t[$];
	typedef pixel_word_t pixel_q_t[$];

	logic        fifo_clk;
	logic        sys_rst;
	logic        node_id;
	logic        word_wr;
	video_word_u word_in;
	logic        line_commit;
	gmii_tx_t    gmii_out;
	logic        fifo_full;

	gmii_video_tx #(
		.SRC_MAC(tb_src_mac),
		.DST_MAC(tb_dst_mac),
		.SRC_IP(tb_src_ip),
		.DST_IP(tb_dst_ip),
		.FIFO_DEPTH(64)
	) DUT (
		.fifo_clk(fifo_clk),
		.sys_rst(sys_rst),
		.node_id(node_id),
		.word_wr(word_wr),
		.word_in(word_in),
		.line_commit(line_commit),
		.gmii_out(gmii_out),
		.fifo_full(fifo_full)
	);

	always #(clk_period / 2) fifo_clk = ~fifo_clk;

	// ----------------------------------------------------------
	// Reference model of a frame
	// ----------------------------------------------------------
	// Preamble, SFD, 42 header bytes, type + coordinates, pixels, FCS
	function automatic int frame_cycles(input int pairs);
		return 8 + 42 + 5 + 4 * pairs + 4;
	endfunction

	// Big endian with the top byte first
	function automatic void push_field(ref byte_q_t q, input logic [47:0] value, input int nbytes);
		for (int i = nbytes - 1; i >= 0; i--) begin
			q.push_back(value[i*8 +: 8]);
		end
	endfunction

	function automatic logic [15:0] ip_checksum(input logic node, input int pairs);
		logic [31:0] sum;
		logic [7:0]  src_lo;
		logic [7:0]  dst_lo;
		src_lo = tb_src_ip[7:0] + 8'(node);
		dst_lo = tb_dst_ip[7:0] - 8'(node);
		sum = 32'h4500 + 32'(33 + 4 * pairs) + 32'h0000 + 32'h4000 + 32'h4011;
		sum = sum + {16'h0, tb_src_ip[31:16]};
		sum = sum + {16'h0, tb_src_ip[15:8], src_lo};
		sum = sum + {16'h0, tb_dst_ip[31:16]};
		sum = sum + {16'h0, tb_dst_ip[15:8], dst_lo};
		while (sum[31:16] != 16'h0) begin
			sum = {16'h0, sum[15:0]} + {16'h0, sum[31:16]};
		end
		return ~sum[15:0];
	endfunction

	// Reflected CRC-32 returned already complemented
	function automatic logic [31:0] fcs_of(input byte_q_t data);
		logic [31:0] c;
		c = 32'hffff_ffff;
		foreach (data[i]) begin
			c = c ^ {24'h0, data[i]};
			for (int b = 0; b < 8; b++) begin
				c = c[0] ? ((c >> 1) ^ 32'hedb8_8320) : (c >> 1);
			end
		end
		return ~c;
	endfunction

	function automatic byte_q_t build_frame(input logic node, input logic [11:0] ly,
			input logic [11:0] cx, input pixel_q_t pixels);
		byte_q_t     q;
		byte_q_t     body;
		logic [31:0] fcs;
		int          pairs;
		pairs = pixels.size();
		push_field(body, {tb_dst_mac[47:8], 8'(tb_dst_mac[7:0] - 8'(node))}, 6);
		push_field(body, {tb_src_mac[47:8], 8'(tb_src_mac[7:0] + 8'(node))}, 6);
		push_field(body, 48'h0800, 2);
		push_field(body, 48'h4500, 2);
		push_field(body, 48'(33 + 4 * pairs), 2);
		push_field(body, 48'h0000_4000_4011, 6);
		push_field(body, 48'(ip_checksum(node, pairs)), 2);
		push_field(body, {tb_src_ip[31:8], 8'(tb_src_ip[7:0] + 8'(node))}, 4);
		push_field(body, {tb_dst_ip[31:8], 8'(tb_dst_ip[7:0] - 8'(node))}, 4);
		push_field(body, 48'h3038_3039, 4);
		push_field(body, 48'(13 + 4 * pairs), 2);
		push_field(body, 48'h0000, 2);
		body.push_back(8'h00);
		push_field(body, {4'h0, ly, 4'h0, cx}, 4);
		foreach (pixels[i]) begin
			push_field(body, pixels[i], 4);
		end
		fcs = fcs_of(body);
		repeat (7) q.push_back(8'h55);
		q.push_back(8'hd5);
		q = {q, body};
		// FCS goes out least significant byte first
		for (int i = 0; i < 4; i++) begin
			q.push_back(fcs[i*8 +: 8]);
		end
		return q;
	endfunction

	function automatic word_q_t make_words(input logic [11:0] ly, input logic [11:0] cx,
			input pixel_q_t pixels);
		word_q_t     q;
		video_word_u w;
		w.coord.line_y = ly;
		w.coord.col_x = cx;
		w.coord.pair_count = 8'(pixels.size());
		q.push_back(w);
		foreach (pixels[i]) begin
			w.pixel = pixels[i];
			q.push_back(w);
		end
		return q;
	endfunction

	function automatic pixel_q_t random_pixels(input int n);
		pixel_q_t q;
		repeat (n) q.push_back(pixel_word_t'($urandom()));
		return q;
	endfunction

	// Distinct bytes per position so a swapped lane shows up
	function automatic pixel_q_t pattern_pixels(input int n);
		pixel_q_t q;
		for (int i = 0; i < n; i++) begin
			q.push_back({8'(8'h10 + i), 8'h80, 8'(8'h20 + i), 8'h90});
		end
		return q;
	endfunction

	// ----------------------------------------------------------
	// Checks
	// ----------------------------------------------------------
	task automatic fail_run(input string msg);
		$display("%s", msg);
		$display("STATUS: FAIL");
		$fatal(1, "simulation stopped at first error");
	endtask

	task automatic compare_gmii(input string test, input int index, input gmii_tx_t expected,
			input gmii_tx_t actual);
		if (actual !== expected) begin
			fail_run($sformatf(
				"** Error [%s] byte %0d: expected en=%0b data=%02h, actual en=%0b data=%02h",
				test, index, expected.en, expected.data, actual.en, actual.data));
		end
	endtask

	task automatic compare_count(input string test, input string what, input int expected,
			input int actual);
		if (actual != expected) begin
			fail_run($sformatf("** Error [%s] %s: expected %0d, actual %0d",
				test, what, expected, actual));
		end
	endtask

	task automatic compare_flag(input string test, input string what, input logic expected,
			input logic actual);
		if (actual !== expected) begin
			fail_run($sformatf("** Error [%s] %s: expected %0b, actual %0b",
				test, what, expected, actual));
		end
	endtask

	// ----------------------------------------------------------
	// Drivers and frame receiver
	// ----------------------------------------------------------
	task automatic write_words(input word_q_t words);
		foreach (words[i]) begin
			@(posedge fifo_clk);
			#1;
			word_wr = 1'b1;
			word_in = words[i];
		end
		@(posedge fifo_clk);
		#1;
		word_wr = 1'b0;
	endtask

	// Commit strobe held high for n cycles in a row
	task automatic commit_lines(input int n);
		@(posedge fifo_clk);
		#1;
		line_commit = 1'b1;
		repeat (n) begin
			@(posedge fifo_clk);
			#1;
		end
		line_commit = 1'b0;
	endtask

	task automatic receive_frame(input string test, input byte_q_t exp);
		int       wait_cnt;
		int       idx;
		int       low_cnt;
		gmii_tx_t want;
		wait_cnt = 0;
		@(negedge fifo_clk);
		while (!gmii_out.en) begin
			wait_cnt++;
			if (wait_cnt > start_limit) begin
				fail_run($sformatf("[%s] no frame started within %0d cycles", test, start_limit));
			end
			@(negedge fifo_clk);
		end
		idx = 0;
		while (gmii_out.en) begin
			if (idx < exp.size()) begin
				want.en = 1'b1;
				want.data = exp[idx];
				compare_gmii(test, idx, want, gmii_out);
			end
			idx++;
			@(negedge fifo_clk);
		end
		compare_count(test, "frame length", exp.size(), idx);
		// First low cycle already seen above
		low_cnt = 1;
		repeat (ifg_cycles - 1) begin
			@(negedge fifo_clk);
			if (!gmii_out.en) begin
				low_cnt++;
			end
		end
		compare_count(test, "gap length", ifg_cycles, low_cnt);
	endtask

	task automatic send_and_check(input string test, input logic node, input logic [11:0] ly,
			input logic [11:0] cx, input pixel_q_t pixels);
		@(posedge fifo_clk);
		#1;
		node_id = node;
		write_words(make_words(ly, cx, pixels));
		commit_lines(1);
		receive_frame(test, build_frame(node, ly, cx, pixels));
	endtask

	// ----------------------------------------------------------
	// Tests
	// ----------------------------------------------------------
	task automatic test_reset_idle();
		repeat (50) begin
			@(negedge fifo_clk);
			compare_gmii("reset_idle", 0, '0, gmii_out);
			compare_flag("reset_idle", "fifo_full", 1'b0, fifo_full);
		end
	endtask

	task automatic test_minimal_line();
		send_and_check("minimal_line", 1'b0, 12'd1, 12'd0, pattern_pixels(4));
	endtask

	task automatic test_node_offset();
		send_and_check("node_offset", 1'b1, 12'd2, 12'd8, pattern_pixels(4));
	endtask

	task automatic test_long_random();
		logic [11:0] ly;
		logic [11:0] cx;
		ly = 12'($urandom());
		cx = 12'($urandom());
		send_and_check("long_random", 1'b0, ly, cx, random_pixels(60));
	endtask

	task automatic test_queued_lines();
		pixel_q_t pa;
		pixel_q_t pb;
		pixel_q_t pc;
		pa = random_pixels(5);
		pb = random_pixels(12);
		pc = random_pixels(20);
		@(posedge fifo_clk);
		#1;
		node_id = 1'b0;
		write_words(make_words(12'd100, 12'd0, pa));
		write_words(make_words(12'd101, 12'd16, pb));
		write_words(make_words(12'd102, 12'd40, pc));
		fork
			commit_lines(3);
			begin
				receive_frame("queued_lines_a", build_frame(1'b0, 12'd100, 12'd0, pa));
				receive_frame("queued_lines_b", build_frame(1'b0, 12'd101, 12'd16, pb));
				receive_frame("queued_lines_c", build_frame(1'b0, 12'd102, 12'd40, pc));
			end
		join
	endtask

	task automatic test_fifo_full();
		pixel_q_t    pixels;
		word_q_t     extra;
		video_word_u junk;
		pixels = random_pixels(63);
		junk.pixel = '1;
		extra.push_back(junk);
		@(negedge fifo_clk);
		compare_flag("fifo_full", "fifo_full before writes", 1'b0, fifo_full);
		write_words(make_words(12'd300, 12'd4, pixels));
		@(negedge fifo_clk);
		compare_flag("fifo_full", "fifo_full after 64 words", 1'b1, fifo_full);
		// Dropped write that must not show up in the frame
		write_words(extra);
		commit_lines(1);
		receive_frame("fifo_full", build_frame(1'b0, 12'd300, 12'd4, pixels));
	endtask

	// ----------------------------------------------------------
	// Watchdog and main sequence
	// ----------------------------------------------------------
	initial begin : watchdog
		int cycles;
		cycles = 0;
		cycles += frame_cycles(4) + ifg_cycles;
		cycles += frame_cycles(4) + ifg_cycles;
		cycles += frame_cycles(60) + ifg_cycles;
		cycles += frame_cycles(5) + ifg_cycles;
		cycles += frame_cycles(12) + ifg_cycles;
		cycles += frame_cycles(20) + ifg_cycles;
		cycles += frame_cycles(63) + ifg_cycles;
		#(2 * cycles * clk_period + 2000);
		fail_run("Watchdog expired before all tests finished");
	end

	initial begin
		void'($urandom(32'hcbb3451d));
		fifo_clk = 1'b0;
		sys_rst = 1'b1;
		node_id = 1'b0;
		word_wr = 1'b0;
		word_in = '0;
		line_commit = 1'b0;
		repeat (2) @(posedge fifo_clk);
		#1;
		sys_rst = 1'b0;

		test_reset_idle();
		test_minimal_line();
		test_node_offset();
		test_long_random();
		test_queued_lines();
		test_fifo_full();

		$display("STATUS: PASS");
		$finish;
	end

endmodule
